/* abuf_params.svh */
`ifndef ABUF_PARAMS_SVH
`define ABUF_PARAMS_SVH

// ====================
// Address and line geometry
// ====================

// Byte address width
`define ABUF_XLEN 32

// One cache line, split into 32-bit words and 16-bit parcels
`define ABUF_LINE_BITS 128
`define ABUF_WORD_BITS 32
`define ABUF_PARCEL_BITS 16
`define ABUF_WORDS 4
`define ABUF_LINE_BYTES 16

// ====================
// Direct-mapped cache shape
// ====================

`define ABUF_NUM_SETS 16
`define ABUF_IDX_W 4
// Byte offset inside a line
`define ABUF_OFFSET_W 4
// Whatever is left above index and offset
`define ABUF_TAG_W 24

`endif

/* abuf_pkg.sv */
`include "abuf_params.svh"

package abuf_pkg;

  // Plain vectors with a meaning
  typedef logic [`ABUF_XLEN-1:0]         abuf_addr_t;
  typedef logic [`ABUF_WORD_BITS-1:0]    abuf_instr_t;
  typedef logic [`ABUF_LINE_BITS-1:0]    abuf_line_t;
  typedef logic [`ABUF_PARCEL_BITS-1:0]  abuf_parcel_t;
  typedef logic [`ABUF_IDX_W-1:0]        abuf_idx_t;
  typedef logic [`ABUF_TAG_W-1:0]        abuf_tag_t;
  typedef logic [$clog2(`ABUF_WORDS)-1:0] abuf_word_sel_t;

  // ====================
  // Port bundles
  // ====================

  typedef struct packed {
    logic       valid;
    abuf_addr_t addr;
  } abuf_fetch_req_t;

  typedef struct packed {
    logic        valid;
    logic        miss;
    abuf_instr_t instr;
  } abuf_fetch_res_t;

  // Address is always line aligned
  typedef struct packed {
    logic       valid;
    abuf_addr_t addr;
  } abuf_mem_req_t;

  typedef struct packed {
    logic       valid;
    abuf_line_t line;
  } abuf_mem_res_t;

  // Decoded request and hit/miss for both lines
  typedef struct packed {
    logic           half_sel;
    abuf_word_sel_t word_sel;
    logic           unalign;
    abuf_idx_t      odd_idx;
    abuf_idx_t      even_idx;
    logic           odd_hit;
    logic           even_hit;
    logic           odd_miss;
    logic           even_miss;
  } abuf_lookup_t;

  // Bank write on a fill
  typedef struct packed {
    logic      en;
    abuf_idx_t even_idx;
    abuf_idx_t odd_idx;
  } abuf_fill_t;

  typedef enum logic {
    ABUF_IDLE,
    ABUF_SECOND
  } abuf_state_e;

endpackage

/* abuf_tag_store.sv */
`timescale 1ns/1ps
`include "abuf_params.svh"

module abuf_tag_store
  import abuf_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            flush_i,
  input  abuf_fetch_req_t fetch_req_i,
  input  abuf_mem_res_t   mem_res_i,
  input  logic            in_second_i,
  output abuf_lookup_t    lookup_o,
  output abuf_fill_t      fill_o
);

  // Valid flag per set, tags kept apart
  logic [`ABUF_NUM_SETS-1:0] valid_q;
  abuf_tag_t                 tag_q [`ABUF_NUM_SETS];

  logic           half_sel;
  abuf_word_sel_t word_sel;
  logic           unalign;
  abuf_idx_t      odd_idx;
  abuf_idx_t      even_idx;
  logic           idx_wrap;
  abuf_tag_t      odd_tag;
  abuf_tag_t      even_tag;
  logic           odd_match;
  logic           even_match;
  logic           fill_odd;
  abuf_idx_t      wr_idx;
  abuf_tag_t      wr_tag;

  // ====================
  // Address decode
  // ====================
  always_comb begin
    half_sel = fetch_req_i.addr[1];
    word_sel = fetch_req_i.addr[`ABUF_OFFSET_W-1:2];
    // Last parcel of the line, upper half lives in the next line
    unalign  = &{word_sel, half_sel};
    odd_idx  = fetch_req_i.addr[`ABUF_IDX_W+`ABUF_OFFSET_W-1:`ABUF_OFFSET_W];
    // Next-line index, wrap past the last set carries into the tag
    {idx_wrap, even_idx} = {1'b0, odd_idx} + (`ABUF_IDX_W+1)'(unalign);
    odd_tag  = fetch_req_i.addr[`ABUF_XLEN-1:`ABUF_IDX_W+`ABUF_OFFSET_W];
    even_tag = idx_wrap ? odd_tag + 1'b1 : odd_tag;
  end

  // Tag compare for both lines
  assign odd_match  = valid_q[odd_idx] && (tag_q[odd_idx] == odd_tag);
  assign even_match = valid_q[even_idx] && (tag_q[even_idx] == even_tag);

  always_comb begin
    lookup_o.half_sel  = half_sel;
    lookup_o.word_sel  = word_sel;
    lookup_o.unalign   = unalign;
    lookup_o.odd_idx   = odd_idx;
    lookup_o.even_idx  = even_idx;
    // Only a live request can hit or miss
    lookup_o.odd_hit   = fetch_req_i.valid && odd_match;
    lookup_o.even_hit  = fetch_req_i.valid && even_match;
    lookup_o.odd_miss  = fetch_req_i.valid && !odd_match;
    lookup_o.even_miss = fetch_req_i.valid && !even_match;
  end

  // ====================
  // Fill decision
  // ====================
  // Odd line goes first, second phase always fills the even line
  assign fill_odd = lookup_o.odd_miss && !in_second_i;
  assign wr_idx   = fill_odd ? odd_idx : even_idx;
  assign wr_tag   = fill_odd ? odd_tag : even_tag;

  always_comb begin
    fill_o.en       = mem_res_i.valid && (lookup_o.odd_miss || lookup_o.even_miss);
    // Both banks take their half of the same arriving line
    fill_o.even_idx = wr_idx;
    fill_o.odd_idx  = wr_idx;
  end

  // Flush is a synchronous clear of every valid flag
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (fill_o.en) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_o.en) begin
      tag_q[wr_idx] <= wr_tag;
    end
  end

endmodule

/* abuf_parcel_bank.sv */
`timescale 1ns/1ps
`include "abuf_params.svh"

module abuf_parcel_bank
  import abuf_pkg::*;
#(
  // 0 keeps the low parcel of each word, 1 the high parcel
  parameter int PARCEL_HALF = 0
) (
  input  logic                             clk_i,
  input  abuf_fill_t                       fill_i,
  input  abuf_idx_t                        rd_idx_i,
  input  abuf_line_t                       line_i,
  output abuf_parcel_t [`ABUF_WORDS-1:0]   parcels_o
);

  // One row of parcels per set
  abuf_parcel_t [`ABUF_WORDS-1:0] mem_q [`ABUF_NUM_SETS];

  abuf_idx_t                      wr_idx;
  abuf_parcel_t [`ABUF_WORDS-1:0] wr_parcels;

  // Each half of the bank pair has its own fill index
  assign wr_idx = (PARCEL_HALF != 0) ? fill_i.odd_idx : fill_i.even_idx;

  // ====================
  // Split the line
  // ====================
  always_comb begin
    for (int w = 0; w < `ABUF_WORDS; w++) begin
      // Pick this bank's half of word w
      wr_parcels[w] =
        line_i[w*`ABUF_WORD_BITS + PARCEL_HALF*`ABUF_PARCEL_BITS +: `ABUF_PARCEL_BITS];
    end
  end

  // Whole row written at the edge of the fill
  always_ff @(posedge clk_i) begin
    if (fill_i.en) begin
      mem_q[wr_idx] <= wr_parcels;
    end
  end

  // Combinational read of the lookup set
  assign parcels_o = mem_q[rd_idx_i];

endmodule

/* abuf_miss_ctrl.sv */
`timescale 1ns/1ps
`include "abuf_params.svh"

module abuf_miss_ctrl
  import abuf_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            flush_i,
  input  abuf_fetch_req_t fetch_req_i,
  input  abuf_lookup_t    lookup_i,
  input  abuf_mem_res_t   mem_res_i,
  output abuf_mem_req_t   mem_req_o,
  output logic            in_second_o
);

  abuf_state_e state_q;
  abuf_state_e state_d;

  logic       double_miss;
  logic       any_miss;
  logic       want_next;
  abuf_addr_t base_addr;

  // Line crossing with neither line present
  assign double_miss = lookup_i.unalign && lookup_i.odd_miss && lookup_i.even_miss;
  assign any_miss    = lookup_i.odd_miss || lookup_i.even_miss;

  // ====================
  // Double-miss FSM
  // ====================
  always_comb begin
    state_d = state_q;
    case (state_q)
      ABUF_IDLE: begin
        // First pulse filled the current line, next line still owed
        if (double_miss && mem_res_i.valid) begin
          state_d = ABUF_SECOND;
        end
      end
      ABUF_SECOND: begin
        if (mem_res_i.valid) begin
          state_d = ABUF_IDLE;
        end
      end
      default: state_d = ABUF_IDLE;
    endcase
    if (flush_i) begin
      state_d = ABUF_IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ABUF_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign in_second_o = (state_q == ABUF_SECOND);

  // ====================
  // Lower-memory request
  // ====================
  // Line base of the fetch address
  assign base_addr = {fetch_req_i.addr[`ABUF_XLEN-1:`ABUF_OFFSET_W], `ABUF_OFFSET_W'(0)};

  // Next line is needed in the second phase, or when only it is missing
  assign want_next = in_second_o ||
                     (lookup_i.unalign && lookup_i.even_miss && !lookup_i.odd_miss);

  always_comb begin
    // Held high until the pulse, dropped in the pulse cycle itself
    mem_req_o.valid = any_miss && !mem_res_i.valid;
    mem_req_o.addr  = want_next ? base_addr + abuf_addr_t'(`ABUF_LINE_BYTES) : base_addr;
  end

endmodule

/* abuf_assemble.sv */
`timescale 1ns/1ps
`include "abuf_params.svh"

module abuf_assemble
  import abuf_pkg::*;
(
  input  abuf_lookup_t                   lookup_i,
  input  abuf_parcel_t [`ABUF_WORDS-1:0] even_parcels_i,
  input  abuf_parcel_t [`ABUF_WORDS-1:0] odd_parcels_i,
  input  abuf_mem_res_t                  mem_res_i,
  input  logic                           in_second_i,
  output abuf_fetch_res_t                fetch_res_o
);

  // Parcel layout of one line
  //   word    |  w3   |  w2   |  w1   |  w0   |
  //   parcel  | O3 E3 | O2 E2 | O1 E1 | O0 E0 |
  //   offset  | E  C  | A  8  | 6  4  | 2  0  |

  abuf_word_sel_t even_word;
  abuf_parcel_t   even_bank;
  abuf_parcel_t   odd_bank;
  abuf_parcel_t   even_line;
  abuf_parcel_t   odd_line;
  abuf_parcel_t   even_parcel;
  abuf_parcel_t   odd_parcel;
  logic           fill_odd;
  logic           even_from_line;
  logic           odd_from_line;
  logic           dual_hit;
  logic           any_miss;
  logic           first_of_double;
  logic           single_done;
  logic           second_done;

  // ====================
  // Parcel selection
  // ====================
  // Even parcel sits one word up on a half offset, or word 0 of the next line
  assign even_word = lookup_i.unalign ? '0 :
                     lookup_i.word_sel + abuf_word_sel_t'(lookup_i.half_sel);

  always_comb begin
    even_bank = even_parcels_i[even_word];
    odd_bank  = odd_parcels_i[lookup_i.word_sel];
    // Same positions taken out of the arriving line
    even_line = mem_res_i.line[even_word*`ABUF_WORD_BITS +: `ABUF_PARCEL_BITS];
    odd_line  = mem_res_i.line[lookup_i.word_sel*`ABUF_WORD_BITS + `ABUF_PARCEL_BITS
                               +: `ABUF_PARCEL_BITS];
  end

  // Which line the pulse carries, same rule as the tag store
  assign fill_odd = lookup_i.odd_miss && !in_second_i;

  // Odd parcel comes from the line only when the current line is arriving
  assign odd_from_line = mem_res_i.valid && fill_odd;

  // Aligned, both parcels share the arriving line
  // Unaligned, only when the next line is the one arriving
  assign even_from_line = mem_res_i.valid && lookup_i.even_miss &&
                          (!lookup_i.unalign || !fill_odd);

  assign even_parcel = even_from_line ? even_line : even_bank;
  assign odd_parcel  = odd_from_line ? odd_line : odd_bank;

  // ====================
  // Assembly and valid
  // ====================
  assign dual_hit        = lookup_i.odd_hit && lookup_i.even_hit;
  assign any_miss        = lookup_i.odd_miss || lookup_i.even_miss;
  // First pulse of a line-crossing double miss, half the data still missing
  assign first_of_double = lookup_i.unalign && lookup_i.odd_miss &&
                           lookup_i.even_miss && !in_second_i;
  assign single_done     = mem_res_i.valid && any_miss && !first_of_double;
  assign second_done     = mem_res_i.valid && in_second_i;

  always_comb begin
    // Lower address in the low half of the instruction
    if (lookup_i.half_sel) begin
      fetch_res_o.instr = {even_parcel, odd_parcel};
    end else begin
      fetch_res_o.instr = {odd_parcel, even_parcel};
    end
    fetch_res_o.valid = dual_hit || single_done || second_done;
    fetch_res_o.miss  = any_miss;
  end

endmodule

/* align_buffer.sv */
`timescale 1ns/1ps
`include "abuf_params.svh"

module align_buffer
  import abuf_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            flush_i,
  input  abuf_fetch_req_t fetch_req_i,
  output abuf_fetch_res_t fetch_res_o,
  output abuf_mem_req_t   mem_req_o,
  input  abuf_mem_res_t   mem_res_i
);

  abuf_lookup_t                   lookup;
  abuf_fill_t                     fill;
  logic                           in_second;
  abuf_parcel_t [`ABUF_WORDS-1:0] even_parcels;
  abuf_parcel_t [`ABUF_WORDS-1:0] odd_parcels;

  // ====================
  // Tags and lookup
  // ====================
  abuf_tag_store u_tag_store (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .fetch_req_i (fetch_req_i),
    .mem_res_i   (mem_res_i),
    .in_second_i (in_second),
    .lookup_o    (lookup),
    .fill_o      (fill)
  );

  // Low halves, read at the next-line index when crossing
  abuf_parcel_bank #(
    .PARCEL_HALF (0)
  ) u_even_bank (
    .clk_i     (clk_i),
    .fill_i    (fill),
    .rd_idx_i  (lookup.even_idx),
    .line_i    (mem_res_i.line),
    .parcels_o (even_parcels)
  );

  // High halves, always the current line
  abuf_parcel_bank #(
    .PARCEL_HALF (1)
  ) u_odd_bank (
    .clk_i     (clk_i),
    .fill_i    (fill),
    .rd_idx_i  (lookup.odd_idx),
    .line_i    (mem_res_i.line),
    .parcels_o (odd_parcels)
  );

  // ====================
  // Miss handling and output
  // ====================
  abuf_miss_ctrl u_miss_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .fetch_req_i (fetch_req_i),
    .lookup_i    (lookup),
    .mem_res_i   (mem_res_i),
    .mem_req_o   (mem_req_o),
    .in_second_o (in_second)
  );

  abuf_assemble u_assemble (
    .lookup_i       (lookup),
    .even_parcels_i (even_parcels),
    .odd_parcels_i  (odd_parcels),
    .mem_res_i      (mem_res_i),
    .in_second_i    (in_second),
    .fetch_res_o    (fetch_res_o)
  );

endmodule

/* tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter real PERIOD_NS    = 4.0,
  parameter int  RESET_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_n_o
);

  // Free-running clock
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
  end

  // Reset held low for a fixed number of rising edges
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

/* tb_align_buffer.sv */
`timescale 1ns/1ps
`include "abuf_params.svh"

module tb_align_buffer
  import abuf_pkg::*;
();

  localparam int          NUM_FETCHES      = 2000;
  localparam int          NUM_DIRECTED     = 8;
  localparam int          CYCLES_PER_FETCH = 20;
  localparam int          MAX_CYCLES       = (NUM_FETCHES + NUM_DIRECTED) * CYCLES_PER_FETCH;
  // 1 KiB window where four tags compete for each set
  localparam abuf_addr_t  WIN_BASE         = 32'h0000_8000;
  localparam int unsigned WIN_BYTES        = 1024;

  logic            clk;
  logic            rst_n;
  logic            flush;
  abuf_fetch_req_t fetch_req;
  abuf_fetch_res_t fetch_res;
  abuf_mem_req_t   mem_req;
  abuf_mem_res_t   mem_res;

  // Tag model of the direct-mapped cache
  logic      model_valid [`ABUF_NUM_SETS];
  abuf_tag_t model_tag   [`ABUF_NUM_SETS];

  int unsigned error_count;
  int unsigned check_count;
  int unsigned hit_count;
  int unsigned miss_count;
  int unsigned double_count;
  int unsigned flush_count;
  int unsigned cycle_count;
  abuf_addr_t  last_addr;

  tb_clk_gen #(
    .PERIOD_NS    (4.0),
    .RESET_CYCLES (10)
  ) u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  align_buffer dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .flush_i     (flush),
    .fetch_req_i (fetch_req),
    .fetch_res_o (fetch_res),
    .mem_req_o   (mem_req),
    .mem_res_i   (mem_res)
  );

  // ====================
  // Memory and tag model
  // ====================
  // Every halfword a mix of all address bits
  function automatic abuf_parcel_t parcel_at(abuf_addr_t addr);
    logic [15:0] lo;
    lo = addr[15:0];
    return lo ^ (lo >> 5) ^ addr[31:16] ^ 16'h3c5a;
  endfunction

  // Parcel k of a line sits at byte offset 2k
  function automatic abuf_line_t line_at(abuf_addr_t line_addr);
    abuf_line_t data;
    for (int k = 0; k < `ABUF_LINE_BITS / `ABUF_PARCEL_BITS; k++) begin
      data[k*`ABUF_PARCEL_BITS +: `ABUF_PARCEL_BITS] = parcel_at(line_addr + abuf_addr_t'(2*k));
    end
    return data;
  endfunction

  function automatic logic line_cached(abuf_addr_t line_addr);
    abuf_idx_t idx;
    idx = line_addr[`ABUF_IDX_W+`ABUF_OFFSET_W-1:`ABUF_OFFSET_W];
    return model_valid[idx] &&
           (model_tag[idx] == line_addr[`ABUF_XLEN-1:`ABUF_IDX_W+`ABUF_OFFSET_W]);
  endfunction

  task automatic model_fill(abuf_addr_t line_addr);
    abuf_idx_t idx;
    idx = line_addr[`ABUF_IDX_W+`ABUF_OFFSET_W-1:`ABUF_OFFSET_W];
    model_valid[idx] = 1'b1;
    model_tag[idx]   = line_addr[`ABUF_XLEN-1:`ABUF_IDX_W+`ABUF_OFFSET_W];
  endtask

  task automatic report_value(string name, logic [31:0] exp_val, logic [31:0] act_val);
    error_count++;
    $display("FAILED t=%0t %s expected %h actual %h", $time, name, exp_val, act_val);
  endtask

  task automatic report_error(string msg);
    error_count++;
    $display("ERROR t=%0t %s", $time, msg);
  endtask

  task automatic print_summary();
    $write("Summary: %0d hits, %0d misses, %0d double misses, ",
           hit_count, miss_count, double_count);
    $display("%0d flushes, %0d checks, %0d errors", flush_count, check_count, error_count);
  endtask

  // Mix of line-crossing, sequential and scattered addresses
  function automatic abuf_addr_t random_addr(abuf_addr_t prev);
    int unsigned pick;
    pick = $urandom % 100;
    if (pick < 25) begin
      return WIN_BASE + abuf_addr_t'(($urandom % 64) * 16 + 14);
    end else if (pick < 55) begin
      // Next parcel wrapping inside the window
      return WIN_BASE + abuf_addr_t'((prev - WIN_BASE + 2) % WIN_BYTES);
    end
    return WIN_BASE + abuf_addr_t'(($urandom % 512) * 2);
  endfunction

  // ====================
  // One fetch with memory responder
  // ====================
  task automatic run_fetch(abuf_addr_t addr);
    abuf_addr_t  odd_line;
    abuf_addr_t  even_line;
    logic        unalign;
    abuf_addr_t  exp_req [$];
    abuf_instr_t exp_instr;
    int          req_seen;
    int          pulses_seen;
    int          delay;
    int          cycle;
    logic        outstanding;
    logic        req_due;
    logic        done;
    abuf_addr_t  req_addr;

    odd_line  = {addr[`ABUF_XLEN-1:`ABUF_OFFSET_W], `ABUF_OFFSET_W'(0)};
    unalign   = (addr[`ABUF_OFFSET_W-1:0] == 4'hE);
    even_line = unalign ? odd_line + `ABUF_LINE_BYTES : odd_line;
    // Lower address in the low half
    exp_instr = {parcel_at(addr + 2), parcel_at(addr)};
    // Current line is always fetched first
    if (!line_cached(odd_line)) exp_req.push_back(odd_line);
    if (unalign && !line_cached(even_line)) exp_req.push_back(even_line);
    if (exp_req.size() == 0) hit_count++;
    else if (exp_req.size() == 1) miss_count++;
    else double_count++;
    req_seen    = 0;
    pulses_seen = 0;
    delay       = 0;
    cycle       = 0;
    outstanding = 1'b0;
    // A miss asks for its line in the request cycle
    req_due     = (exp_req.size() != 0);
    done        = 1'b0;
    req_addr    = '0;

    @(posedge clk);
    fetch_req     <= '{valid: 1'b1, addr: addr};
    mem_res.valid <= 1'b0;
    while (!done) begin
      @(negedge clk);
      if (mem_res.valid) begin
        pulses_seen++;
        outstanding = 1'b0;
        // Next line of a crossing is asked for in the following cycle
        req_due     = (pulses_seen < exp_req.size());
      end else if (outstanding) begin
        // Level request held until the line arrives
        if (!mem_req.valid) begin
          report_error("mem_req_o.valid dropped before the response");
        end else if (mem_req.addr != req_addr) begin
          report_value("mem_req_o.addr", req_addr, mem_req.addr);
        end
      end else if (mem_req.valid) begin
        check_count++;
        if (req_seen >= exp_req.size()) begin
          report_value("mem_req_o.valid", 32'd0, 32'd1);
        end else if (mem_req.addr != exp_req[req_seen]) begin
          report_value("mem_req_o.addr", exp_req[req_seen], mem_req.addr);
        end
        req_addr    = mem_req.addr;
        req_seen++;
        outstanding = 1'b1;
        req_due     = 1'b0;
        delay       = 1 + $urandom % 6;
      end else if (req_due) begin
        report_error("mem_req_o.valid low in the cycle the request was due");
        req_due = 1'b0;
      end
      if (fetch_res.valid) begin
        done = 1'b1;
        check_count += 4;
        if (fetch_res.instr != exp_instr) begin
          report_value("fetch_res_o.instr", exp_instr, fetch_res.instr);
        end
        if (fetch_res.miss != (exp_req.size() != 0)) begin
          report_value("fetch_res_o.miss", exp_req.size() != 0, fetch_res.miss);
        end
        if (pulses_seen != exp_req.size() || req_seen != exp_req.size()) begin
          report_error($sformatf("addr %h answered after %0d requests, %0d expected",
                                 addr, req_seen, exp_req.size()));
        end
        if (exp_req.size() == 0 && cycle != 0) begin
          report_error("hit answered after the request cycle");
        end
        if (exp_req.size() != 0 && !mem_res.valid) begin
          report_error("valid outside a response pulse");
        end
      end else if (exp_req.size() == 0 && cycle == 0) begin
        report_error($sformatf("no valid in the request cycle of hit addr %h", addr));
      end
      if (!done) begin
        @(posedge clk);
        cycle++;
        if (delay == 1) mem_res <= '{valid: 1'b1, line: line_at(req_addr)};
        else mem_res.valid <= 1'b0;
        if (delay > 0) delay--;
      end
    end
    model_fill(odd_line);
    model_fill(even_line);
  endtask

  task automatic do_flush();
    @(posedge clk);
    fetch_req.valid <= 1'b0;
    mem_res.valid   <= 1'b0;
    flush           <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    for (int s = 0; s < `ABUF_NUM_SETS; s++) model_valid[s] = 1'b0;
    flush_count++;
  endtask

  // ====================
  // Main sequence
  // ====================
  initial begin
    abuf_addr_t  addr;
    int unsigned seed_ret;
    seed_ret     = $urandom(32'hee49);
    flush        = 1'b0;
    fetch_req    = '0;
    mem_res      = '0;
    error_count  = 0;
    check_count  = 0;
    hit_count    = 0;
    miss_count   = 0;
    double_count = 0;
    flush_count  = 0;
    cycle_count  = 0;
    last_addr    = WIN_BASE;
    for (int s = 0; s < `ABUF_NUM_SETS; s++) model_valid[s] = 1'b0;
    @(posedge rst_n);
    repeat (2) @(posedge clk);

    // Miss then hit, then another tag in the same set evicts it
    run_fetch(WIN_BASE + 32'h20);
    run_fetch(WIN_BASE + 32'h22);
    run_fetch(WIN_BASE + 32'h120);
    run_fetch(WIN_BASE + 32'h20);
    // Line crossing with both lines absent and then a hit
    run_fetch(WIN_BASE + 32'h3E);
    run_fetch(WIN_BASE + 32'h3E);
    do_flush();
    run_fetch(WIN_BASE + 32'h3E);
    run_fetch(WIN_BASE + 32'h20);

    for (int n = 0; n < NUM_FETCHES; n++) begin
      if (($urandom % 50) == 0) begin
        // Address cached before the flush goes to memory again
        do_flush();
        addr = last_addr;
      end else begin
        addr = random_addr(last_addr);
      end
      run_fetch(addr);
      last_addr = addr;
    end

    @(posedge clk);
    fetch_req.valid <= 1'b0;
    mem_res.valid   <= 1'b0;
    @(posedge clk);
    print_summary();
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Watchdog on total run length
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      report_error($sformatf("run did not finish within %0d cycles", MAX_CYCLES));
      print_summary();
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

endmodule

/* align_buffer.f */
+incdir+.
abuf_pkg.sv
abuf_tag_store.sv
abuf_parcel_bank.sv
abuf_miss_ctrl.sv
abuf_assemble.sv
align_buffer.sv
tb_clk_gen.sv
tb_align_buffer.sv
